//--- Makefile
# Verilator build and run of the IoU matching stage testbench
SIM      ?= verilator
FLAGS    ?= --binary --assert -Wno-fatal
TOP      ?= oflow_iou_tb
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
# keep running past the first assertion error so the report line is printed
RUN_ARGS ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' src.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) src.f
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f src.f

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/oflow_iou_chk.sv
// concurrent checks on the pair FIFO strobes and the calculator latency
// bound into the FIFO and the calculator at the bottom of this file
`timescale 1ns/1ps
`default_nettype none

module oflow_iou_chk #(
   parameter bit LAT_EN = 1'b0
) (
   input wire logic clk,
   input wire logic reset_N,
   input wire logic push,
   input wire logic full,
   input wire logic pop,
   input wire logic empty,
   input wire logic iou_valid
);

   int fails = 0;

   // generator holds off on a full FIFO
   push_not_full: assert property (@(posedge clk) disable iff (reset_N) push |-> !full)
      else begin
         $error("push while the pair FIFO is full");
         fails++;
      end

   pop_not_empty: assert property (@(posedge clk) disable iff (reset_N) pop |-> !empty)
      else begin
         $error("pop while the pair FIFO is empty");
         fails++;
      end

   // result 13 cycles after each pop and at no other time
   pop_to_result: assert property (@(posedge clk) disable iff (reset_N)
      LAT_EN |-> (iou_valid == $past(pop, 13)))
      else begin
         $error("iou_valid not 13 cycles after pop");
         fails++;
      end

endmodule

bind oflow_pair_fifo oflow_iou_chk #(.LAT_EN(1'b0)) i_fifo_chk (
   .clk       (clk),
   .reset_N   (reset_N),
   .push      (port.push),
   .full      (port.full),
   .pop       (port.pop),
   .empty     (port.empty),
   .iou_valid (1'b0)
);

bind oflow_calc_iou oflow_iou_chk #(.LAT_EN(1'b1)) i_calc_chk (
   .clk       (clk),
   .reset_N   (reset_N),
   .push      (1'b0),
   .full      (1'b0),
   .pop       (pair.pop),
   .empty     (pair.empty),
   .iou_valid (score.iou_valid)
);

`default_nettype wire

//--- dv/oflow_iou_monitor.sv
// reference model and scoreboard for the IoU matching stage
// mirrors the history table from the top-level ports and checks each pair and frame match
`timescale 1ns/1ps
`default_nettype none

module oflow_iou_monitor (
   input  wire logic                                   clk,
   input  wire logic                                   reset_N,
   input  wire logic                                   hist_wr,
   input  wire logic [oflow_track_pkg::HIST_IDX_W-1:0] hist_idx,
   input  wire oflow_geom_pkg::bbox_t                  hist_bbox,
   input  wire logic                                   frame_start,
   input  wire oflow_geom_pkg::bbox_t                  frame_bbox,
   input  wire logic                                   frame_busy,
   input  wire logic                                   iou_valid,
   input  wire logic [oflow_geom_pkg::IOU_W-1:0]       iou,
   input  wire logic [oflow_track_pkg::HIST_IDX_W-1:0] iou_idx,
   input  wire logic                                   match_valid,
   input  wire logic [oflow_track_pkg::HIST_IDX_W-1:0] match_idx,
   input  wire logic [oflow_geom_pkg::IOU_W-1:0]       match_iou,
   input  wire logic [3:0]                             exp_idx,
   output int                                          pass_cnt,
   output int                                          fail_cnt
);
   import oflow_geom_pkg::*;
   import oflow_track_pkg::*;

   bbox_t                 hist [HIST_DEPTH];
   logic [HIST_DEPTH-1:0] vld;
   int                    pair_iou_q [$];
   int                    pair_idx_q [$];
   int                    frame_iou_q [$];
   int                    frame_idx_q [$];
   int                    table_idx_q [$];
   int                    n_pass = 0;
   int                    n_fail = 0;
   // frame accepted on the previous edge
   bit                    start_q = 1'b0;

   assign pass_cnt = n_pass;
   assign fail_cnt = n_fail;

   // --------------------------------------------------------------------------
   // reference IoU
   // --------------------------------------------------------------------------
   // shared length of two spans on one axis and zero when they only touch
   function automatic longint overlap(input logic [COORD_W-1:0] lo_a, hi_a, lo_b, hi_b);
      int lo;
      int hi;
      lo = (lo_a > lo_b) ? int'(lo_a) : int'(lo_b);
      hi = (hi_a < hi_b) ? int'(hi_a) : int'(hi_b);
      return (hi > lo) ? longint'(hi - lo) : 0;
   endfunction

   function automatic longint area(input bbox_t b);
      return longint'(int'(b.x_br) - int'(b.x_tl)) * longint'(int'(b.y_br) - int'(b.y_tl));
   endfunction

   function automatic int ref_iou(input bbox_t a, input bbox_t b);
      longint inter;
      longint uni;
      inter = overlap(a.x_tl, a.x_br, b.x_tl, b.x_br) * overlap(a.y_tl, a.y_br, b.y_tl, b.y_br);
      uni   = area(a) + area(b) - inter;
      return (uni == 0) ? 0 : int'(inter * 1024 / uni);
   endfunction

   function automatic bit check(input string name, input int want, input int got);
      if (want != got) begin
         $display("ERROR %s expected 0x%0h actual 0x%0h", name, want, got);
      end
      return want == got;
   endfunction

   task automatic tally(input bit ok, input string what);
      if (ok) begin
         n_pass++;
      end else begin
         n_fail++;
      end
      $display("%s %s", what, ok ? "ok" : "FAILED");
   endtask

   // --------------------------------------------------------------------------
   // expectations and comparisons
   // --------------------------------------------------------------------------
   task automatic expect_frame();
      int best_iou;
      int best_idx;
      int v;
      best_iou = -1;
      best_idx = 0;
      for (int i = 0; i < HIST_DEPTH; i++) begin
         if (vld[i]) begin
            v = ref_iou(frame_bbox, hist[i]);
            pair_iou_q.push_back(v);
            pair_idx_q.push_back(i);
            // strictly greater so a tie stays with the lower index
            if (v > best_iou) begin
               best_iou = v;
               best_idx = i;
            end
         end
      end
      frame_iou_q.push_back(best_iou);
      frame_idx_q.push_back(best_idx);
      table_idx_q.push_back(int'(exp_idx));
   endtask

   task automatic check_pair();
      bit ok;
      if (pair_iou_q.size() == 0) begin
         n_fail++;
         $display("result for entry %0d arrived with no pair outstanding", iou_idx);
      end else begin
         ok = check("iou_idx", pair_idx_q.pop_front(), int'(iou_idx));
         ok &= check("iou", pair_iou_q.pop_front(), int'(iou));
         tally(ok, $sformatf("pair entry %0d iou %0d", iou_idx, iou));
      end
   endtask

   task automatic check_match();
      bit ok;
      int tab;
      if (frame_iou_q.size() == 0) begin
         n_fail++;
         $display("frame match reported with no frame accepted");
      end else begin
         // all pairs of the frame are out before the match
         ok = (pair_iou_q.size() == 0);
         if (!ok) begin
            $display("frame match reported with %0d pair results missing", pair_iou_q.size());
            pair_iou_q.delete();
            pair_idx_q.delete();
         end
         // walk ends well before the last pair has been divided
         ok &= check("frame_busy", 0, int'(frame_busy));
         ok &= check("match_idx", frame_idx_q.pop_front(), int'(match_idx));
         ok &= check("match_iou", frame_iou_q.pop_front(), int'(match_iou));
         tab = table_idx_q.pop_front();
         if (tab != 15) begin
            ok &= check("match_idx (table)", tab, int'(match_idx));
         end
         tally(ok, $sformatf("frame match entry %0d iou %0d", match_idx, match_iou));
      end
   endtask

   // outputs sampled here still hold their values from before this edge
   always @(posedge clk) begin
      if (reset_N) begin
         vld     = '0;
         start_q = 1'b0;
         pair_iou_q.delete();
         pair_idx_q.delete();
         frame_iou_q.delete();
         frame_idx_q.delete();
         table_idx_q.delete();
      end else begin
         // results first so that a frame accepted on this edge is not counted as outstanding
         if (iou_valid) begin
            check_pair();
         end
         if (match_valid) begin
            check_match();
         end
         // walk running one cycle after an accepted start
         if (start_q && !check("frame_busy", 1, int'(frame_busy))) begin
            n_fail++;
         end
         start_q = 1'b0;
         if (hist_wr && !frame_busy) begin
            hist[hist_idx] = hist_bbox;
            vld[hist_idx]  = 1'b1;
         end
         if (frame_start && !frame_busy && (vld != '0)) begin
            expect_frame();
            start_q = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- dv/oflow_iou_tb.sv
// testbench for the IoU matching stage with hand-picked table rows then random rows
// each row reloads the history after a short reset and runs its frame twice
`timescale 1ns/1ps
`default_nettype none

module oflow_iou_tb;
   import oflow_geom_pkg::*;
   import oflow_track_pkg::*;

   // history entry i takes library box sel[3*i +: 3] (one octal digit per entry)
   typedef struct packed {
      logic [7:0]  mask;
      logic [23:0] sel;
      logic [2:0]  frame_sel;
      logic [3:0]  exp_idx;
   } row_t;

   localparam int N_TAB  = 5;
   localparam int N_RAND = 24;
   // two frames per row of up to 8 pairs at 14 cycles plus slack
   localparam int MAX_CYCLES = 10 + (N_TAB + N_RAND) * 2 * (8 * 14 + 20) + 400;

   logic                  clk = 1'b0;
   logic                  reset_N;
   logic                  hist_wr;
   logic [HIST_IDX_W-1:0] hist_idx;
   bbox_t                 hist_bbox;
   logic                  frame_start;
   bbox_t                 frame_bbox;
   logic                  frame_busy;
   logic                  iou_valid;
   logic [IOU_W-1:0]      iou;
   logic [HIST_IDX_W-1:0] iou_idx;
   logic                  match_valid;
   logic [HIST_IDX_W-1:0] match_idx;
   logic [IOU_W-1:0]      match_iou;
   // table match index or 4'hf on random rows
   logic [3:0]            exp_idx;
   int                    pass_cnt;
   int                    fail_cnt;
   int                    cycles = 0;
   bbox_t                 lib [8];
   row_t                  rows [N_TAB];

   oflow_iou_top     i_dut (.*);
   oflow_iou_monitor i_mon (.*);

   always #10 clk = ~clk;

   // --------------------------------------------------------------------------
   // run limit
   // --------------------------------------------------------------------------
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, a frame match never arrived", cycles);
         $display("Verification failed");
         $finish;
      end
   end

   // ordered corners kept small so boxes overlap often
   function automatic bbox_t rand_box();
      bbox_t b;
      b.x_tl = 11'($urandom_range(0, 300));
      b.y_tl = 11'($urandom_range(0, 300));
      b.x_br = b.x_tl + 11'($urandom_range(0, 200));
      b.y_br = b.y_tl + 11'($urandom_range(0, 200));
      return b;
   endfunction

   // start a frame and optionally poke it while busy then wait for the match
   task automatic run_frame(input bbox_t frame, input bit poke);
      frame_start = 1'b1;
      frame_bbox  = frame;
      @(negedge clk);
      frame_start = 1'b0;
      if (poke) begin
         @(negedge clk);
         // walk still running so both get dropped
         hist_wr     = 1'b1;
         hist_idx    = 3'd5;
         hist_bbox   = lib[1];
         frame_start = 1'b1;
         frame_bbox  = lib[2];
         @(negedge clk);
         hist_wr     = 1'b0;
         frame_start = 1'b0;
      end
      while (!match_valid) begin
         @(negedge clk);
      end
      // match pulse reaches the monitor before the next reset or start
      @(negedge clk);
   endtask

   task automatic run_row(input logic [7:0] mask, input bbox_t [7:0] boxes,
                          input bbox_t frame, input logic [3:0] want_idx);
      reset_N = 1'b1;
      repeat (2) @(negedge clk);
      reset_N = 1'b0;
      exp_idx = want_idx;
      for (int i = 0; i < HIST_DEPTH; i++) begin
         if (mask[i]) begin
            hist_wr   = 1'b1;
            hist_idx  = HIST_IDX_W'(i);
            hist_bbox = boxes[i];
            @(negedge clk);
         end
      end
      hist_wr = 1'b0;
      run_frame(frame, 1'b1);
      run_frame(frame, 1'b0);
   endtask

   // --------------------------------------------------------------------------
   // stimulus
   // --------------------------------------------------------------------------
   initial begin
      bbox_t [7:0] boxes;
      bbox_t       frame;
      logic [7:0]  mask;
      int          assert_fails;
      void'($urandom(32'h5ac0));
      reset_N     = 1'b1;
      hist_wr     = 1'b0;
      hist_idx    = '0;
      hist_bbox   = '0;
      frame_start = 1'b0;
      frame_bbox  = '0;
      exp_idx     = 4'hf;
      // box library as x_tl, y_tl, x_br, y_br
      lib[0] = {11'd100, 11'd100, 11'd200, 11'd200};
      lib[1] = {11'd150, 11'd150, 11'd250, 11'd250};
      lib[2] = {11'd300, 11'd300, 11'd400, 11'd400};
      // shares only the right edge of box 0
      lib[3] = {11'd200, 11'd100, 11'd300, 11'd200};
      lib[4] = {11'd120, 11'd120, 11'd180, 11'd180};
      // zero width
      lib[5] = {11'd100, 11'd100, 11'd100, 11'd200};
      lib[6] = {11'd100, 11'd100, 11'd200, 11'd200};
      lib[7] = {11'd50, 11'd50, 11'd150, 11'd150};
      // identical boxes
      rows[0] = {8'h01, 24'o00000000, 3'd0, 4'd0};
      // disjoint and edge-touching boxes all give zero so the lowest entry keeps it
      rows[1] = {8'h0c, 24'o00003200, 3'd0, 4'd2};
      // all eight valid so the FIFO fills
      rows[2] = {8'hff, 24'o16354712, 3'd0, 4'd6};
      // tie at 146 between entries 1 and 7
      rows[3] = {8'h82, 24'o10000070, 3'd0, 4'd1};
      // degenerate frame box with one pair of zero union
      rows[4] = {8'h11, 24'o00050000, 3'd5, 4'd0};
      repeat (10) @(negedge clk);
      reset_N = 1'b0;
      for (int r = 0; r < N_TAB; r++) begin
         for (int i = 0; i < HIST_DEPTH; i++) begin
            boxes[i] = lib[rows[r].sel[3*i +: 3]];
         end
         run_row(rows[r].mask, boxes, lib[rows[r].frame_sel], rows[r].exp_idx);
      end
      for (int r = 0; r < N_RAND; r++) begin
         mask = 8'($urandom);
         if (mask == '0) begin
            mask = 8'h01;
         end
         for (int i = 0; i < HIST_DEPTH; i++) begin
            boxes[i] = rand_box();
         end
         frame = rand_box();
         run_row(mask, boxes, frame, 4'hf);
      end
      repeat (4) @(negedge clk);
      assert_fails = i_dut.i_pair_fifo.i_fifo_chk.fails + i_dut.i_calc_iou.i_calc_chk.fails;
      $display("tests passed %0d failed %0d, assertion failures %0d",
               pass_cnt, fail_cnt, assert_fails);
      if (fail_cnt == 0 && assert_fails == 0 && pass_cnt > 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- source/oflow_calc_iou.sv
// IoU of one frame/history pair as intersection*1024/union, rounded down
// pops a pair when idle, result pulses 13 cycles after the pop
`timescale 1ns/1ps
`default_nettype none

module oflow_calc_iou (
   input  wire logic   clk,
   input  wire logic   reset_N,
   oflow_pair_if.calc  pair,
   oflow_score_if.calc score
);
   import oflow_geom_pkg::*;
   import oflow_track_pkg::*;

   typedef enum logic [1:0] {idle_st, coord_st, inter_st, div_st} state_t;

   state_t                state;
   bbox_t                 box_k;
   bbox_t                 box_h;
   logic [COORD_W-1:0]    x_tl_q;
   logic [COORD_W-1:0]    y_tl_q;
   logic [COORD_W-1:0]    x_br_q;
   logic [COORD_W-1:0]    y_br_q;
   logic [AREA_W-1:0]     area_k_q;
   logic [AREA_W-1:0]     area_h_q;
   logic [AREA_W-1:0]     inter_c;
   // union up to twice one area
   logic [AREA_W:0]       union_q;
   logic [AREA_W+1:0]     rem_q;
   logic [AREA_W+1:0]     rem_sub;
   logic                  rem_ge;
   logic [IOU_W-1:0]      quot_q;
   logic [3:0]            step_cnt;
   logic                  step_en;
   logic [HIST_IDX_W-1:0] idx_q;
   logic                  last_q;

   // zero when the edges cross or touch
   function automatic logic [COORD_W-1:0] span(input logic [COORD_W-1:0] lo,
                                                input logic [COORD_W-1:0] hi);
      return (hi > lo) ? hi - lo : '0;
   endfunction

   function automatic logic [AREA_W-1:0] area(input bbox_t b);
      return AREA_W'(span(b.x_tl, b.x_br)) * AREA_W'(span(b.y_tl, b.y_br));
   endfunction

   // --------------------------------------------------------------------------
   // corners and areas, latched on pop
   // --------------------------------------------------------------------------
   assign box_k    = pair.rd_data.frame_box;
   assign box_h    = pair.rd_data.hist_box;
   assign pair.pop = (state == idle_st) && !pair.empty;

   always_ff @(posedge clk) begin
      if (pair.pop) begin
         // larger top-left, smaller bottom-right
         x_tl_q   <= (box_k.x_tl > box_h.x_tl) ? box_k.x_tl : box_h.x_tl;
         y_tl_q   <= (box_k.y_tl > box_h.y_tl) ? box_k.y_tl : box_h.y_tl;
         x_br_q   <= (box_k.x_br < box_h.x_br) ? box_k.x_br : box_h.x_br;
         y_br_q   <= (box_k.y_br < box_h.y_br) ? box_k.y_br : box_h.y_br;
         area_k_q <= area(box_k);
         area_h_q <= area(box_h);
         idx_q    <= pair.rd_data.idx;
         last_q   <= pair.rd_data.last;
      end
   end

   assign inter_c = AREA_W'(span(x_tl_q, x_br_q)) * AREA_W'(span(y_tl_q, y_br_q));

   // --------------------------------------------------------------------------
   // restoring divider, one quotient bit per step, msb first
   // --------------------------------------------------------------------------
   // intersection never exceeds union so 11 steps cover 0..1024
   // zero union forces every bit low
   assign rem_ge  = (union_q != '0) && (rem_q >= {1'b0, union_q});
   assign rem_sub = rem_ge ? rem_q - {1'b0, union_q} : rem_q;
   assign step_en = (state == inter_st) || ((state == div_st) && (step_cnt != 4'(IOU_W)));

   always_ff @(posedge clk) begin
      if (state == coord_st) begin
         union_q <= {1'b0, area_k_q} + {1'b0, area_h_q} - {1'b0, inter_c};
         rem_q   <= {2'b00, inter_c};
         quot_q  <= '0;
      end else if (step_en) begin
         rem_q  <= {rem_sub[AREA_W:0], 1'b0};
         quot_q <= {quot_q[IOU_W-2:0], rem_ge};
      end
   end

   // --------------------------------------------------------------------------
   // FSM and step counter
   // --------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset_N) begin
      if (reset_N) begin
         state    <= idle_st;
         step_cnt <= '0;
      end else begin
         if (state == coord_st) begin
            step_cnt <= '0;
         end else if (step_en) begin
            step_cnt <= step_cnt + 1'b1;
         end
         case (state)
            idle_st:  state <= pair.pop ? coord_st : idle_st;
            coord_st: state <= inter_st;
            inter_st: state <= div_st;
            // result cycle after the last step, then back to idle
            default:  state <= (step_cnt == 4'(IOU_W)) ? idle_st : div_st;
         endcase
      end
   end

   assign score.iou_valid = (state == div_st) && (step_cnt == 4'(IOU_W));
   assign score.iou       = quot_q;
   assign score.idx       = idx_q;
   assign score.last      = last_q;

endmodule

`default_nettype wire

//--- source/oflow_geom_pkg.sv
// box geometry and fixed-point formats shared by the IoU matching stage
// import wherever boxes, areas or IoU values are handled
`default_nettype none

package oflow_geom_pkg;

   // --------------------------------------------------------------------------
   // coordinates and boxes
   // --------------------------------------------------------------------------
   localparam int COORD_W = 11;

   // top-left corner sits in the upper bits
   typedef struct packed {
      logic [COORD_W-1:0] x_tl;
      logic [COORD_W-1:0] y_tl;
      logic [COORD_W-1:0] x_br;
      logic [COORD_W-1:0] y_br;
   } bbox_t;

   // --------------------------------------------------------------------------
   // areas and IoU
   // --------------------------------------------------------------------------
   // product of two spans
   localparam int AREA_W = 2 * COORD_W;

   // IoU scaled by 1024
   localparam int IOU_FRAC_BITS = 10;
   // one integer bit so that full overlap fits
   localparam int IOU_W = IOU_FRAC_BITS + 1;

endpackage

`default_nettype wire

//--- source/oflow_iou_top.sv
// top of the matching stage with plain ports
// generator feeds the FIFO, calculator drains it, selector picks the frame match
`timescale 1ns/1ps
`default_nettype none

module oflow_iou_top (
   input  wire logic                                   clk,
   input  wire logic                                   reset_N,
   // history write
   input  wire logic                                   hist_wr,
   input  wire logic [oflow_track_pkg::HIST_IDX_W-1:0] hist_idx,
   input  wire oflow_geom_pkg::bbox_t                  hist_bbox,
   // frame request
   input  wire logic                                   frame_start,
   input  wire oflow_geom_pkg::bbox_t                  frame_bbox,
   output logic                                        frame_busy,
   // per-pair result
   output logic                                        iou_valid,
   output logic [oflow_geom_pkg::IOU_W-1:0]            iou,
   output logic [oflow_track_pkg::HIST_IDX_W-1:0]      iou_idx,
   // frame result
   output logic                                        match_valid,
   output logic [oflow_track_pkg::HIST_IDX_W-1:0]      match_idx,
   output logic [oflow_geom_pkg::IOU_W-1:0]            match_iou
);

   oflow_pair_if  pair_bus ();
   oflow_score_if score_bus ();

   oflow_pair_gen i_pair_gen (
      .clk         (clk),
      .reset_N     (reset_N),
      .hist_wr     (hist_wr),
      .hist_idx    (hist_idx),
      .hist_bbox   (hist_bbox),
      .frame_start (frame_start),
      .frame_bbox  (frame_bbox),
      .frame_busy  (frame_busy),
      .pair        (pair_bus.gen)
   );

   oflow_pair_fifo i_pair_fifo (
      .clk     (clk),
      .reset_N (reset_N),
      .port    (pair_bus.fifo)
   );

   oflow_calc_iou i_calc_iou (
      .clk     (clk),
      .reset_N (reset_N),
      .pair    (pair_bus.calc),
      .score   (score_bus.calc)
   );

   oflow_match_select i_match_select (
      .clk         (clk),
      .reset_N     (reset_N),
      .score       (score_bus.sel),
      .match_valid (match_valid),
      .match_idx   (match_idx),
      .match_iou   (match_iou)
   );

   // per-pair results straight off the score bus
   assign iou_valid = score_bus.iou_valid;
   assign iou       = score_bus.iou;
   assign iou_idx   = score_bus.idx;

endmodule

`default_nettype wire

//--- source/oflow_match_select.sv
// best-match selector over one frame's per-pair IoU results
// strictly greater wins, so ties stay with the lower history index
`timescale 1ns/1ps
`default_nettype none

module oflow_match_select (
   input  wire logic                                   clk,
   input  wire logic                                   reset_N,
   oflow_score_if.sel                                  score,
   output logic                                        match_valid,
   output logic [oflow_track_pkg::HIST_IDX_W-1:0]      match_idx,
   output logic [oflow_geom_pkg::IOU_W-1:0]            match_iou
);
   import oflow_geom_pkg::*;
   import oflow_track_pkg::*;

   logic                  have_best;
   logic [IOU_W-1:0]      best_iou;
   logic [HIST_IDX_W-1:0] best_idx;
   logic                  take;
   logic [IOU_W-1:0]      win_iou;
   logic [HIST_IDX_W-1:0] win_idx;

   // first pair of a frame always taken
   assign take    = !have_best || (score.iou > best_iou);
   assign win_iou = take ? score.iou : best_iou;
   assign win_idx = take ? score.idx : best_idx;

   always_ff @(posedge clk or posedge reset_N) begin
      if (reset_N) begin
         have_best   <= 1'b0;
         match_valid <= 1'b0;
      end else begin
         match_valid <= score.iou_valid && score.last;
         // last pair closes the frame and drops the running best
         if (score.iou_valid) begin
            have_best <= !score.last;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (score.iou_valid) begin
         best_iou <= win_iou;
         best_idx <= win_idx;
         if (score.last) begin
            match_iou <= win_iou;
            match_idx <= win_idx;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/oflow_pair_fifo.sv
// small synchronous FIFO holding pairs between generator and calculator
// head is visible on rd_data while empty is low
`timescale 1ns/1ps
`default_nettype none

module oflow_pair_fifo #(
   parameter int DEPTH = oflow_track_pkg::FIFO_DEPTH
) (
   input  wire logic  clk,
   input  wire logic  reset_N,
   oflow_pair_if.fifo port
);
   import oflow_track_pkg::*;

   // pointer and occupancy widths follow DEPTH
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   pair_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_wr;
   logic             do_rd;

   // circular wrap for any depth
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign do_wr        = port.push && !port.full;
   assign do_rd        = port.pop && !port.empty;
   assign port.full    = (count == CNT_W'(DEPTH));
   assign port.empty   = (count == '0);
   assign port.rd_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= port.wr_data;
      end
   end

   always_ff @(posedge clk or posedge reset_N) begin
      if (reset_N) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_rd) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         // simultaneous push and pop leaves the count alone
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/oflow_pair_gen.sv
// history table plus the walker that pairs a new frame box with every valid entry
// one entry visited per cycle, stalls on a full pair FIFO
`timescale 1ns/1ps
`default_nettype none

module oflow_pair_gen (
   input  wire logic                                   clk,
   input  wire logic                                   reset_N,
   input  wire logic                                   hist_wr,
   input  wire logic [oflow_track_pkg::HIST_IDX_W-1:0] hist_idx,
   input  wire oflow_geom_pkg::bbox_t                  hist_bbox,
   input  wire logic                                   frame_start,
   input  wire oflow_geom_pkg::bbox_t                  frame_bbox,
   output logic                                        frame_busy,
   oflow_pair_if.gen                                   pair
);
   import oflow_geom_pkg::*;
   import oflow_track_pkg::*;

   bbox_t                 hist_mem [HIST_DEPTH];
   logic [HIST_DEPTH-1:0] hist_vld;
   logic [HIST_DEPTH-1:0] vld_next;
   bbox_t                 frame_box_q;
   logic [HIST_IDX_W-1:0] walk_idx;
   logic [HIST_IDX_W-1:0] last_idx;
   logic [HIST_IDX_W-1:0] top_idx;
   logic                  hist_wr_ok;
   logic                  frame_go;
   logic                  cur_vld;
   logic                  advance;

   // --------------------------------------------------------------------------
   // history table
   // --------------------------------------------------------------------------
   // table frozen during a walk
   assign hist_wr_ok = hist_wr && !frame_busy;

   always_comb begin
      vld_next = hist_vld;
      if (hist_wr_ok) begin
         vld_next[hist_idx] = 1'b1;
      end
   end

   // highest valid entry gets the last flag
   always_comb begin
      top_idx = '0;
      for (int i = 0; i < HIST_DEPTH; i++) begin
         if (vld_next[i]) begin
            top_idx = HIST_IDX_W'(i);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (hist_wr_ok) begin
         hist_mem[hist_idx] <= hist_bbox;
      end
      if (frame_go) begin
         frame_box_q <= frame_bbox;
      end
   end

   // --------------------------------------------------------------------------
   // walker
   // --------------------------------------------------------------------------
   // start only when idle and something to compare against
   assign frame_go = frame_start && !frame_busy && (|vld_next);
   assign cur_vld  = hist_vld[walk_idx];
   // invalid entries pass in one cycle, valid ones wait for room
   assign advance  = !cur_vld || !pair.full;

   always_ff @(posedge clk or posedge reset_N) begin
      if (reset_N) begin
         hist_vld   <= '0;
         frame_busy <= 1'b0;
         walk_idx   <= '0;
         last_idx   <= '0;
      end else begin
         hist_vld <= vld_next;
         if (frame_go) begin
            frame_busy <= 1'b1;
            walk_idx   <= '0;
            last_idx   <= top_idx;
         end else if (frame_busy && advance) begin
            walk_idx <= walk_idx + 1'b1;
            if (walk_idx == HIST_IDX_W'(HIST_DEPTH - 1)) begin
               frame_busy <= 1'b0;
            end
         end
      end
   end

   assign pair.push              = frame_busy && cur_vld && !pair.full;
   assign pair.wr_data.frame_box = frame_box_q;
   assign pair.wr_data.hist_box  = hist_mem[walk_idx];
   assign pair.wr_data.idx       = walk_idx;
   assign pair.wr_data.last      = (walk_idx == last_idx);

endmodule

`default_nettype wire

//--- source/oflow_pair_if.sv
// pair path from the generator through the FIFO into the IoU calculator
// plain push/pop strobes with full and empty levels
`timescale 1ns/1ps
`default_nettype none

interface oflow_pair_if;
   import oflow_track_pkg::*;

   // write side
   logic  push;
   pair_t wr_data;
   logic  full;

   // read side, head valid while empty is low
   logic  pop;
   pair_t rd_data;
   logic  empty;

   modport gen  (output push, output wr_data, input full);
   modport fifo (input push, input wr_data, output full,
                 input pop, output rd_data, output empty);
   modport calc (output pop, input rd_data, input empty);

endinterface

`default_nettype wire

//--- source/oflow_score_if.sv
// per-pair IoU results from the calculator to the best-match selector
`timescale 1ns/1ps
`default_nettype none

interface oflow_score_if;
   import oflow_geom_pkg::*;
   import oflow_track_pkg::*;

   // one-cycle pulse, rest valid with it
   logic                  iou_valid;
   logic [IOU_W-1:0]      iou;
   logic [HIST_IDX_W-1:0] idx;
   logic                  last;

   modport calc (output iou_valid, output iou, output idx, output last);
   modport sel  (input iou_valid, input iou, input idx, input last);

endinterface

`default_nettype wire

//--- source/oflow_track_pkg.sv
// history table sizing and the pair record moved between tracker blocks
// import in blocks that index the history or carry pairs
`default_nettype none

package oflow_track_pkg;

   // --------------------------------------------------------------------------
   // history table
   // --------------------------------------------------------------------------
   localparam int HIST_DEPTH = 8;
   localparam int HIST_IDX_W = $clog2(HIST_DEPTH);

   // pairs waiting for the calculator
   localparam int FIFO_DEPTH = 4;

   // --------------------------------------------------------------------------
   // pair record
   // --------------------------------------------------------------------------
   // one frame box against one history box
   typedef struct packed {
      oflow_geom_pkg::bbox_t  frame_box;
      oflow_geom_pkg::bbox_t  hist_box;
      logic [HIST_IDX_W-1:0]  idx;
      // final pair of the frame
      logic                   last;
   } pair_t;

endpackage

`default_nettype wire

//--- src.f
source/oflow_geom_pkg.sv
source/oflow_track_pkg.sv
source/oflow_pair_if.sv
source/oflow_score_if.sv
source/oflow_pair_gen.sv
source/oflow_pair_fifo.sv
source/oflow_calc_iou.sv
source/oflow_match_select.sv
source/oflow_iou_top.sv
dv/oflow_iou_monitor.sv
dv/oflow_iou_chk.sv
dv/oflow_iou_tb.sv
